// ==== src/mcont_pkg.sv ====
package mcont_pkg;

	// Bus widths shared by the memory and the controller
	localparam int ADDR_W = 11;
	localparam int DATA_W = 32;
	localparam int BE_W   = 4;

	// Mailbox words in data memory
	localparam logic [ADDR_W-1:0] CMD_ADDR = 11'd0;
	localparam logic [ADDR_W-1:0] TXD_ADDR = 11'd1;
	// SPI receive byte lands here, zero-extended
	localparam logic [ADDR_W-1:0] RXD_ADDR = 11'd2;

	// Protocol field of the command word
	typedef enum logic [1:0] {
		PROTO_SPI  = 2'd0,
		PROTO_UART = 2'd1
	} proto_e;

	// Command word
	// Upper four bits mean the same in both views
	typedef union packed {
		struct packed {
			logic        start;
			logic        done;
			proto_e      proto;
			logic [24:0] rsvd;
			// Bit order on MOSI and MISO
			logic        lsb_first;
			// Which of the four selects
			logic [1:0]  ss_idx;
		} spi;
		struct packed {
			logic        start;
			logic        done;
			proto_e      proto;
			logic [25:0] rsvd;
			logic        two_stop;
			// Even parity after the data bits
			logic        parity_en;
		} uart;
	} ctrl_word_u;

endpackage

// ==== src/datamem.sv ====
module datamem #(
	parameter int DEPTH = 2048
) (
	input  logic                         clk,

	// Port A, processor side
	input  logic [mcont_pkg::ADDR_W-1:0] a_addr_i,
	input  logic [mcont_pkg::BE_W-1:0]   a_we_i,
	input  logic [mcont_pkg::DATA_W-1:0] a_wdata_i,
	output logic [mcont_pkg::DATA_W-1:0] a_rdata_o,

	// Port B, controller side
	input  logic [mcont_pkg::ADDR_W-1:0] b_addr_i,
	input  logic [mcont_pkg::BE_W-1:0]   b_we_i,
	input  logic [mcont_pkg::DATA_W-1:0] b_wdata_i,
	output logic [mcont_pkg::DATA_W-1:0] b_rdata_o
);

	// Word storage
	logic [mcont_pkg::DATA_W-1:0] mem [DEPTH];

	// Byte-lane writes on both ports
	// Port A lane written last so it wins on a collision
	always_ff @(posedge clk) begin
		for (int i = 0; i < mcont_pkg::BE_W; i++) begin
			if (b_we_i[i]) begin
				mem[b_addr_i][8*i +: 8] <= b_wdata_i[8*i +: 8];
			end
			if (a_we_i[i]) begin
				mem[a_addr_i][8*i +: 8] <= a_wdata_i[8*i +: 8];
			end
		end
	end

	// Registered reads, old data on a same-cycle write
	always_ff @(posedge clk) begin
		a_rdata_o <= mem[a_addr_i];
		b_rdata_o <= mem[b_addr_i];
	end

endmodule

// ==== src/spi_master.sv ====
module spi_master #(
	parameter int CLK_DIV = 4
) (
	input  logic       clk,
	input  logic       arst_n_i,

	// Controller side
	input  logic       start_i,
	input  logic [7:0] tx_byte_i,
	input  logic [1:0] ss_idx_i,
	input  logic       lsb_first_i,
	output logic       done_o,
	output logic [7:0] rx_byte_o,

	// SPI pins, mode 0
	output logic       sck_o,
	output logic       mosi_o,
	input  logic       miso_i,
	output logic [3:0] ss_n_o
);

	localparam int DIV_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	logic             busy;
	logic [DIV_W-1:0] div_cnt;
	// Last clock of an SCK half period
	logic             half_end;
	logic [2:0]       bit_cnt;
	logic [7:0]       tx_sh;
	logic [7:0]       rx_sh;
	logic             lsb_q;

	assign half_end = (div_cnt == DIV_W'(CLK_DIV - 1));

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy    <= 1'b0;
			div_cnt <= '0;
			bit_cnt <= '0;
			tx_sh   <= '0;
			lsb_q   <= 1'b0;
			sck_o   <= 1'b0;
			ss_n_o  <= 4'hF;
			done_o  <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (!busy) begin
				div_cnt <= '0;
				if (start_i) begin
					busy    <= 1'b1;
					bit_cnt <= '0;
					lsb_q   <= lsb_first_i;
					// Byte is always shifted out from bit 7
					// so LSB-first loads it mirrored
					tx_sh   <= lsb_first_i ? {<<{tx_byte_i}} : tx_byte_i;
					ss_n_o  <= ~(4'b0001 << ss_idx_i);
				end
			end else if (half_end) begin
				div_cnt <= '0;
				sck_o   <= ~sck_o;
				// SCK high now, so this is a falling edge
				if (sck_o) begin
					if (bit_cnt == 3'd7) begin
						// Eighth bit done, release the slave
						busy   <= 1'b0;
						done_o <= 1'b1;
						ss_n_o <= 4'hF;
						tx_sh  <= '0;
					end else begin
						bit_cnt <= bit_cnt + 3'd1;
						tx_sh   <= {tx_sh[6:0], 1'b0};
					end
				end
			end else begin
				div_cnt <= div_cnt + 1'b1;
			end
		end
	end

	// MISO capture on the rising edge of SCK
	always_ff @(posedge clk) begin
		if (busy && half_end && !sck_o) begin
			if (lsb_q) begin
				rx_sh <= {miso_i, rx_sh[7:1]};
			end else begin
				rx_sh <= {rx_sh[6:0], miso_i};
			end
		end
	end

	assign mosi_o    = tx_sh[7];
	// Holds until the next start
	assign rx_byte_o = rx_sh;

endmodule

// ==== src/uart_enc.sv ====
module uart_enc #(
	parameter int BAUD_DIV = 16
) (
	input  logic       clk,
	input  logic       arst_n_i,
	input  logic       start_i,
	input  logic [7:0] tx_byte_i,
	input  logic       parity_en_i,
	input  logic       two_stop_i,
	output logic       done_o,
	output logic       tx_o
);

	localparam int BAUD_W = (BAUD_DIV > 1) ? $clog2(BAUD_DIV) : 1;

	logic              busy;
	logic [BAUD_W-1:0] baud_cnt;
	logic              bit_end;
	logic [3:0]        bit_cnt;
	// Index of the final stop bit, 9 to 11
	logic [3:0]        last_bit;
	logic [11:0]       frame;
	logic [11:0]       frame_sh;
	logic              parity;

	// Even parity, set when the byte has an odd count of ones
	assign parity = ^tx_byte_i;

	// Start bit in bit 0, data LSB first
	// Spare upper positions are ones, same as stop bits
	always_comb begin
		if (parity_en_i) begin
			frame = {2'b11, parity, tx_byte_i, 1'b0};
		end else begin
			frame = {3'b111, tx_byte_i, 1'b0};
		end
	end

	assign bit_end = (baud_cnt == BAUD_W'(BAUD_DIV - 1));

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			busy     <= 1'b0;
			baud_cnt <= '0;
			bit_cnt  <= '0;
			last_bit <= '0;
			frame_sh <= '1;
			done_o   <= 1'b0;
		end else begin
			done_o <= 1'b0;
			if (!busy) begin
				baud_cnt <= '0;
				if (start_i) begin
					busy     <= 1'b1;
					bit_cnt  <= '0;
					frame_sh <= frame;
					last_bit <= 4'd9 + {3'b000, parity_en_i} + {3'b000, two_stop_i};
				end
			end else if (bit_end) begin
				baud_cnt <= '0;
				// Ones shift in behind the frame
				frame_sh <= {1'b1, frame_sh[11:1]};
				if (bit_cnt == last_bit) begin
					busy     <= 1'b0;
					done_o   <= 1'b1;
					frame_sh <= '1;
				end else begin
					bit_cnt <= bit_cnt + 4'd1;
				end
			end else begin
				baud_cnt <= baud_cnt + 1'b1;
			end
		end
	end

	// Line idles high
	assign tx_o = frame_sh[0];

endmodule

// ==== src/mcont.sv ====
module mcont #(
	parameter int CLK_DIV  = 4,
	parameter int BAUD_DIV = 16
) (
	input  logic                         clk,
	input  logic                         arst_n_i,

	// Data memory port B
	output logic [mcont_pkg::ADDR_W-1:0] mem_addr_o,
	output logic [mcont_pkg::BE_W-1:0]   mem_we_o,
	output logic [mcont_pkg::DATA_W-1:0] mem_wdata_o,
	input  logic [mcont_pkg::DATA_W-1:0] mem_rdata_i,

	// SPI pins
	output logic                         sck_o,
	output logic                         mosi_o,
	input  logic                         miso_i,
	output logic [3:0]                   ss_n_o,

	// UART transmit pin
	output logic                         uart_enc_o,

	// End-of-transfer pulse to the core
	output logic                         int_sig_o
);

	// FSM states
	localparam logic [2:0] S_IDLE   = 3'd0;
	localparam logic [2:0] S_FETCH  = 3'd1;
	localparam logic [2:0] S_LAUNCH = 3'd2;
	localparam logic [2:0] S_WAIT   = 3'd3;
	localparam logic [2:0] S_WB_RX  = 3'd4;
	localparam logic [2:0] S_WB_CMD = 3'd5;

	logic [2:0]            state;
	// Read data holds a fresh command word poll
	logic                  poll_vld;
	logic                  cmd_hit;
	mcont_pkg::ctrl_word_u cmd_rd;
	mcont_pkg::ctrl_word_u cmd_q;
	mcont_pkg::ctrl_word_u cmd_wb;
	logic                  is_spi;
	logic                  is_uart;
	logic                  spi_start;
	logic                  spi_done;
	logic [7:0]            spi_rx;
	logic                  uart_start;
	logic                  uart_done;

	assign cmd_rd  = mcont_pkg::ctrl_word_u'(mem_rdata_i);
	assign cmd_hit = (state == S_IDLE) && poll_vld && cmd_rd.spi.start;

	// Protocol field is common to both views
	assign is_spi  = (cmd_q.spi.proto == mcont_pkg::PROTO_SPI);
	assign is_uart = (cmd_q.uart.proto == mcont_pkg::PROTO_UART);

	// One-cycle launch, TX word is on the read data in S_LAUNCH
	assign spi_start  = (state == S_LAUNCH) && is_spi;
	assign uart_start = (state == S_LAUNCH) && is_uart;

	// Completed command: start cleared, done set, rest kept
	always_comb begin
		cmd_wb           = cmd_q;
		cmd_wb.spi.start = 1'b0;
		cmd_wb.spi.done  = 1'b1;
	end

	// Memory port B address and write control
	always_comb begin
		mem_addr_o  = mcont_pkg::CMD_ADDR;
		mem_we_o    = '0;
		mem_wdata_o = cmd_wb;
		case (state)
			S_FETCH: begin
				mem_addr_o = mcont_pkg::TXD_ADDR;
			end
			S_WB_RX: begin
				mem_addr_o  = mcont_pkg::RXD_ADDR;
				mem_we_o    = '1;
				mem_wdata_o = {{(mcont_pkg::DATA_W-8){1'b0}}, spi_rx};
			end
			S_WB_CMD: begin
				mem_we_o = '1;
			end
			default: begin
			end
		endcase
	end

	always_ff @(posedge clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			state     <= S_IDLE;
			poll_vld  <= 1'b0;
			int_sig_o <= 1'b0;
		end else begin
			// Read data trails the address by one cycle
			poll_vld  <= (state == S_IDLE);
			// Pulse lands after the command word is written
			int_sig_o <= (state == S_WB_CMD);
			case (state)
				S_IDLE: begin
					if (cmd_hit) begin
						state <= S_FETCH;
					end
				end
				S_FETCH: begin
					state <= S_LAUNCH;
				end
				S_LAUNCH: begin
					// Unknown protocol just completes
					state <= (is_spi || is_uart) ? S_WAIT : S_WB_CMD;
				end
				S_WAIT: begin
					if (spi_done) begin
						state <= S_WB_RX;
					end else if (uart_done) begin
						state <= S_WB_CMD;
					end
				end
				S_WB_RX: begin
					state <= S_WB_CMD;
				end
				default: begin
					state <= S_IDLE;
				end
			endcase
		end
	end

	// Command captured at the poll that saw start
	always_ff @(posedge clk) begin
		if (cmd_hit) begin
			cmd_q <= cmd_rd;
		end
	end

	spi_master #(
		.CLK_DIV(CLK_DIV)
	) spi (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.start_i     (spi_start),
		.tx_byte_i   (mem_rdata_i[7:0]),
		.ss_idx_i    (cmd_q.spi.ss_idx),
		.lsb_first_i (cmd_q.spi.lsb_first),
		.done_o      (spi_done),
		.rx_byte_o   (spi_rx),
		.sck_o       (sck_o),
		.mosi_o      (mosi_o),
		.miso_i      (miso_i),
		.ss_n_o      (ss_n_o)
	);

	uart_enc #(
		.BAUD_DIV(BAUD_DIV)
	) uart (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.start_i     (uart_start),
		.tx_byte_i   (mem_rdata_i[7:0]),
		.parity_en_i (cmd_q.uart.parity_en),
		.two_stop_i  (cmd_q.uart.two_stop),
		.done_o      (uart_done),
		.tx_o        (uart_enc_o)
	);

endmodule

// ==== src/top.sv ====
module top #(
	parameter int DEPTH    = 2048,
	parameter int CLK_DIV  = 4,
	parameter int BAUD_DIV = 16
) (
	input  logic                         clk,
	input  logic                         arst_n_i,

	// Processor memory port
	input  logic [mcont_pkg::ADDR_W-1:0] core_addr_i,
	input  logic [mcont_pkg::BE_W-1:0]   core_we_i,
	input  logic [mcont_pkg::DATA_W-1:0] core_wdata_i,
	output logic [mcont_pkg::DATA_W-1:0] core_rdata_o,

	// SPI pins
	output logic                         sck_o,
	output logic                         mosi_o,
	input  logic                         miso_i,
	output logic [3:0]                   ss_n_o,

	// UART pins
	output logic                         uart_enc_o,
	// Reserved for a receiver, not connected yet
	input  logic                         uart_dec_i,

	output logic                         int_sig_o
);

	// Controller side of the data memory
	logic [mcont_pkg::ADDR_W-1:0] con_addr;
	logic [mcont_pkg::BE_W-1:0]   con_we;
	logic [mcont_pkg::DATA_W-1:0] con_wdata;
	logic [mcont_pkg::DATA_W-1:0] con_rdata;

	// Shared data memory, port A to the core
	datamem #(
		.DEPTH(DEPTH)
	) mem (
		.clk       (clk),
		.a_addr_i  (core_addr_i),
		.a_we_i    (core_we_i),
		.a_wdata_i (core_wdata_i),
		.a_rdata_o (core_rdata_o),
		.b_addr_i  (con_addr),
		.b_we_i    (con_we),
		.b_wdata_i (con_wdata),
		.b_rdata_o (con_rdata)
	);

	// Protocol controller with SPI and UART engines
	mcont #(
		.CLK_DIV  (CLK_DIV),
		.BAUD_DIV (BAUD_DIV)
	) protocol_con (
		.clk         (clk),
		.arst_n_i    (arst_n_i),
		.mem_addr_o  (con_addr),
		.mem_we_o    (con_we),
		.mem_wdata_o (con_wdata),
		.mem_rdata_i (con_rdata),
		.sck_o       (sck_o),
		.mosi_o      (mosi_o),
		.miso_i      (miso_i),
		.ss_n_o      (ss_n_o),
		.uart_enc_o  (uart_enc_o),
		.int_sig_o   (int_sig_o)
	);

endmodule

// ==== dv/mcont_assert.sv ====
module mcont_assert (
	input logic       clk,
	input logic       arst_n_i,
	input logic       sck_o,
	input logic [3:0] ss_n_o,
	input logic       int_sig_o
);

	// Never two slaves on the bus
	ss_onehot: assert property (@(posedge clk) disable iff (!arst_n_i)
		$onehot0(~ss_n_o))
		else $error("more than one slave select low, ss_n %b", ss_n_o);

	// Interrupt is a single-cycle pulse
	int_pulse: assert property (@(posedge clk) disable iff (!arst_n_i)
		int_sig_o |=> !int_sig_o)
		else $error("int_sig_o held high for two cycles");

	// SCK parked low outside a transfer
	sck_idle: assert property (@(posedge clk) disable iff (!arst_n_i)
		(ss_n_o == 4'hF) |-> !sck_o)
		else $error("SCK high with no slave selected");

endmodule

bind mcont mcont_assert chk (
	.clk       (clk),
	.arst_n_i  (arst_n_i),
	.sck_o     (sck_o),
	.ss_n_o    (ss_n_o),
	.int_sig_o (int_sig_o)
);

// ==== dv/top_tb.sv ====
module top_tb;

	localparam int DEPTH    = 2048;
	localparam int CLK_DIV  = 4;
	localparam int BAUD_DIV = 16;
	// Number of vector lines
	localparam int NT       = 9;
	// Longest frame per test plus bus and FSM overhead
	localparam int WD_CYCLES = NT * (12 * BAUD_DIV + 48) + 64;

	logic                         clk;
	logic                         arst_n_i;
	logic [mcont_pkg::ADDR_W-1:0] core_addr;
	logic [mcont_pkg::BE_W-1:0]   core_we;
	logic [mcont_pkg::DATA_W-1:0] core_wdata;
	logic [mcont_pkg::DATA_W-1:0] core_rdata;
	logic                         sck;
	logic                         mosi;
	logic                         miso;
	logic [3:0]                   ss_n;
	logic                         uart_tx;
	logic                         uart_dec;
	logic                         int_sig;

	// Four words per test
	logic [31:0] vec [4*NT];
	int          n_checks;
	int          n_errors;
	int          test_errs;

	top #(
		.DEPTH    (DEPTH),
		.CLK_DIV  (CLK_DIV),
		.BAUD_DIV (BAUD_DIV)
	) dut (
		.clk          (clk),
		.arst_n_i     (arst_n_i),
		.core_addr_i  (core_addr),
		.core_we_i    (core_we),
		.core_wdata_i (core_wdata),
		.core_rdata_o (core_rdata),
		.sck_o        (sck),
		.mosi_o       (mosi),
		.miso_i       (miso),
		.ss_n_o       (ss_n),
		.uart_enc_o   (uart_tx),
		.uart_dec_i   (uart_dec),
		.int_sig_o    (int_sig)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic check_word(input string name, input logic [mcont_pkg::DATA_W-1:0] exp,
			input logic [mcont_pkg::DATA_W-1:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			test_errs++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			test_errs++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	task automatic check_ctrl(input string name, input mcont_pkg::ctrl_word_u exp,
			input mcont_pkg::ctrl_word_u act);
		n_checks++;
		if (act !== exp) begin
			n_errors++;
			test_errs++;
			$display("Fail %s: expected %h, actual %h", name, exp, act);
		end
	endtask

	// Core port write landing on the second edge
	task automatic mem_write(input logic [mcont_pkg::ADDR_W-1:0] addr,
			input logic [mcont_pkg::DATA_W-1:0] data);
		@(posedge clk);
		core_addr  <= addr;
		core_we    <= '1;
		core_wdata <= data;
		@(posedge clk);
		core_we    <= '0;
	endtask

	// Registered read sampled mid-cycle
	task automatic mem_read(input logic [mcont_pkg::ADDR_W-1:0] addr,
			output logic [mcont_pkg::DATA_W-1:0] data);
		@(posedge clk);
		core_addr <= addr;
		core_we   <= '0;
		@(posedge clk);
		@(negedge clk);
		data = core_rdata;
	endtask

	// Mode 0 SPI slave
	task automatic spi_slave(input string name, input mcont_pkg::ctrl_word_u cmd,
			input logic [7:0] tx_b, input logic [7:0] miso_b);
		logic [3:0] ss_exp;
		logic [7:0] mosi_cap;
		logic       lsb;
		lsb      = cmd.spi.lsb_first;
		// Only the indexed select is low
		for (int j = 0; j < 4; j++) begin
			ss_exp[j] = (j != int'(cmd.spi.ss_idx));
		end
		mosi_cap = '0;
		wait (ss_n != 4'hF);
		check_byte({name, "_ss"}, {4'h0, ss_exp}, {4'h0, ss_n});
		// First bit out before the first rising edge
		miso <= lsb ? miso_b[0] : miso_b[7];
		for (int i = 0; i < 8; i++) begin
			@(posedge sck);
			mosi_cap[lsb ? i : 7 - i] = mosi;
			if (i < 7) begin
				@(negedge sck);
				miso <= lsb ? miso_b[i + 1] : miso_b[6 - i];
			end
		end
		check_byte({name, "_mosi"}, tx_b, mosi_cap);
	endtask

	// Mid-bit UART line sampler
	task automatic uart_sample(input string name, input mcont_pkg::ctrl_word_u cmd,
			input logic [7:0] tx_b);
		logic       start_bit;
		logic [7:0] data;
		logic       par;
		logic [1:0] stops;
		data  = '0;
		par   = 1'b0;
		stops = '0;
		@(negedge uart_tx);
		repeat (BAUD_DIV / 2) @(negedge clk);
		start_bit = uart_tx;
		// Data LSB first
		for (int i = 0; i < 8; i++) begin
			repeat (BAUD_DIV) @(negedge clk);
			data[i] = uart_tx;
		end
		if (cmd.uart.parity_en) begin
			repeat (BAUD_DIV) @(negedge clk);
			par = uart_tx;
		end
		repeat (BAUD_DIV) @(negedge clk);
		stops[0] = uart_tx;
		if (cmd.uart.two_stop) begin
			repeat (BAUD_DIV) @(negedge clk);
			stops[1] = uart_tx;
		end
		check_byte({name, "_start"}, 8'h00, {7'h0, start_bit});
		check_byte({name, "_data"}, tx_b, data);
		// Odd count of ones over data and parity is an error
		if (cmd.uart.parity_en) begin
			check_byte({name, "_parity"}, 8'h00, {7'h0, ^{data, par}});
		end
		check_byte({name, "_stop"}, cmd.uart.two_stop ? 8'h03 : 8'h01, {6'h0, stops});
	endtask

	function automatic string test_name(input int idx, input mcont_pkg::ctrl_word_u c);
		if (c.spi.proto == mcont_pkg::PROTO_SPI) begin
			return $sformatf("t%0d_spi_ss%0d_%s", idx, c.spi.ss_idx,
				c.spi.lsb_first ? "lsb" : "msb");
		end
		return $sformatf("t%0d_uart_par%0d_stop%0d", idx, c.uart.parity_en,
			c.uart.two_stop ? 2 : 1);
	endfunction

	task automatic run_test(input int idx);
		mcont_pkg::ctrl_word_u        cmd;
		mcont_pkg::ctrl_word_u        exp_cmd;
		logic [mcont_pkg::DATA_W-1:0] got_rx;
		logic [mcont_pkg::DATA_W-1:0] got_cmd;
		string                        name;
		cmd       = mcont_pkg::ctrl_word_u'(vec[4*idx]);
		name      = test_name(idx, cmd);
		test_errs = 0;
		fork
			begin
				mem_write(mcont_pkg::TXD_ADDR, vec[4*idx + 1]);
				mem_write(mcont_pkg::CMD_ADDR, cmd);
				@(posedge int_sig);
			end
			begin
				if (cmd.spi.proto == mcont_pkg::PROTO_SPI) begin
					spi_slave(name, cmd, vec[4*idx + 1][7:0], vec[4*idx + 2][7:0]);
				end else begin
					uart_sample(name, cmd, vec[4*idx + 1][7:0]);
				end
			end
		join
		mem_read(mcont_pkg::RXD_ADDR, got_rx);
		mem_read(mcont_pkg::CMD_ADDR, got_cmd);
		// Start in bit 31 cleared and done in bit 30 set
		exp_cmd = mcont_pkg::ctrl_word_u'({2'b01, vec[4*idx][29:0]});
		check_word({name, "_rxd"}, vec[4*idx + 3], got_rx);
		check_ctrl({name, "_cmd"}, exp_cmd, mcont_pkg::ctrl_word_u'(got_cmd));
		$display("%s finished with %0d errors", name, test_errs);
	endtask

	// Watchdog
	initial begin
		repeat (WD_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, a transfer never completed", WD_CYCLES);
		$display("Test failed");
		$finish;
	end

	initial begin
		arst_n_i   = 1'b0;
		core_addr  = '0;
		core_we    = '0;
		core_wdata = '0;
		miso       = 1'b0;
		uart_dec   = 1'b1;
		n_checks   = 0;
		n_errors   = 0;
		test_errs  = 0;
		$readmemh("dv/top_vectors.txt", vec);
		repeat (2) @(posedge clk);
		arst_n_i <= 1'b1;
		@(posedge clk);
		@(negedge clk);
		// Idle levels of sck, mosi, uart, int and ss_n
		check_byte("reset_pins", 8'h2F, {sck, mosi, uart_tx, int_sig, ss_n});
		$display("reset finished with %0d errors", test_errs);
		if ($isunknown(vec[0]) || $isunknown(vec[4*NT - 1])) begin
			n_errors++;
			$display("Vector file dv/top_vectors.txt is missing or too short");
		end else begin
			for (int t = 0; t < NT; t++) begin
				run_test(t);
			end
		end
		$display("Tests %0d, checks %0d, errors %0d", NT, n_checks, n_errors);
		if (n_errors == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

// ==== dv/top_vectors.txt ====
// cmd_word  tx_word  miso_byte  exp_rxd_word
// SPI command word: bit 2 lsb_first, bits 1..0 slave index
80000000 000000a5 3c 0000003c
80000001 0000005a c3 000000c3
80000002 00000081 7e 0000007e
80000003 0000000f f0 000000f0
// SPI LSB first on slave 1
80000005 00000013 2b 0000002b
// UART command word: bit 1 two_stop, bit 0 parity_en
// RXD keeps the last SPI byte
90000000 00000047 00 0000002b
90000003 000000d6 00 0000002b
90000001 00000035 00 0000002b
// SPI LSB first on slave 2
80000006 000000c8 91 00000091

// ==== verilog.f ====
src/mcont_pkg.sv
src/datamem.sv
src/spi_master.sv
src/uart_enc.sv
src/mcont.sv
src/top.sv
dv/mcont_assert.sv
dv/top_tb.sv

// ==== Makefile ====
TOP := top_tb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f verilog.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "Test completed successfully"

clean:
	rm -rf obj_dir
